// File: source/arrayPkg.sv
/*
  Shared widths and vector types for the array heap
  Action codes, error codes and sequencer states
*/
package arrayPkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int addressBits = 2;                    // Bits in an array number
  localparam int indexBits   = 3;                    // Bits in an element index
  localparam int dataBits    = 16;                   // Width of one element
  localparam int arrayCount  = 4;                    // Arrays in the heap
  localparam int arrayLength = 8;                    // Max elements per array

  typedef logic [addressBits-1:0] arrayId;           // Names an array
  typedef logic [indexBits-1:0]   elementIndex;      // Position within an array
  typedef logic [indexBits:0]     elementCount;      // Size, 0 to arrayLength
  typedef logic [dataBits-1:0]    dataWord;          // Element, operand or result
  typedef logic [addressBits:0]   allocCount;        // Arrays handed out so far

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------
  typedef enum logic [7:0] {
    heapReset = 8'd1,                                // Drop all allocations
    write     = 8'd2,                                // Store an element
    read      = 8'd3,                                // Fetch an element
    size      = 8'd4,                                // Current array size
    push      = 8'd14,                               // Append at the end
    pop       = 8'd15,                               // Remove from the end
    alloc     = 8'd18,                               // Claim an array
    free      = 8'd19,                               // Release an array
    add       = 8'd20,                               // Returns new value
    addAfter  = 8'd21,                               // Returns old value
    subtract  = 8'd22,                               // Returns new value
    subAfter  = 8'd23,                               // Returns old value
    bitOr     = 8'd28,
    bitXor    = 8'd29,
    bitAnd    = 8'd30
  } arrayAction;

  typedef enum logic [2:0] {
    none,                                            // Command succeeded
    notAllocated,                                    // Array at or above count
    freed,                                           // Array not currently held
    outOfBounds,                                     // Index at or past size
    arrayFull,                                       // Push at arrayLength
    arrayEmpty,                                      // Pop at size 0
    outOfMemory                                      // No array left to grant
  } arrayError;

  typedef enum logic [1:0] {idle, lookup, execute, finish} sequencerState;

endpackage

// File: source/storeBus.sv
/*
  Element and size access between sequencer and element store
*/
interface storeBus;

  arrayPkg::arrayId      array;                      // Selected array
  arrayPkg::elementIndex index;                      // Selected element
  arrayPkg::dataWord     writeData;                  // Element to store
  logic                  writeEnable;                // Element write strobe
  arrayPkg::elementCount newSize;                    // Size to store
  logic                  sizeEnable;                 // Size write strobe
  arrayPkg::dataWord     readData;                   // Element, one edge late
  arrayPkg::elementCount currentSize;                // Size, one edge late

  modport sequencer (
    output array,
    output index,
    output writeData,
    output writeEnable,
    output newSize,
    output sizeEnable,
    input  readData,
    input  currentSize
  );

  modport store (
    input  array,
    input  index,
    input  writeData,
    input  writeEnable,
    input  newSize,
    input  sizeEnable,
    output readData,
    output currentSize
  );

endinterface

// File: source/arrayAllocator.sv
/*
  Array allocator: allocation counter, stack of freed arrays,
  per-array allocated flags and the checks built on them
*/
module arrayAllocator (
  input  logic             clock,
  input  logic             resetN,
  input  logic             allocRequest,          // Grant grantedArray
  input  logic             freeRequest,           // Release array
  input  logic             clearRequest,          // Heap reset
  input  arrayPkg::arrayId array,                 // Array under check
  output arrayPkg::arrayId grantedArray,          // Next array to hand out
  output logic             canAllocate,
  output logic             isAllocated,
  output logic             isBelowCount
);

  arrayPkg::allocCount             count;         // Fresh arrays handed out
  arrayPkg::allocCount             freeTop;       // Entries on the free stack
  arrayPkg::arrayId                freeStack [arrayPkg::arrayCount];
  logic [arrayPkg::arrayCount-1:0] allocated;     // One flag per array
  logic                            stackEmpty;

  assign stackEmpty   = freeTop == '0;
  assign grantedArray = stackEmpty ? arrayPkg::arrayId'(count)
                                   : freeStack[arrayPkg::arrayId'(freeTop - 1'b1)];  // Last freed first
  assign canAllocate  = !stackEmpty || count < arrayPkg::allocCount'(arrayPkg::arrayCount);
  assign isBelowCount = arrayPkg::allocCount'(array) < count;
  assign isAllocated  = isBelowCount && allocated[array];

  // ------------------------------------------------
  // Counter, stack pointer and flags
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      count     <= '0;
      freeTop   <= '0;
      allocated <= '0;
    end else if (clearRequest) begin
      count     <= '0;                            // Forget every allocation
      freeTop   <= '0;
      allocated <= '0;
    end else if (allocRequest) begin
      if (!stackEmpty) begin
        freeTop <= freeTop - 1'b1;                // Reuse a freed array
      end else begin
        count <= count + 1'b1;                    // Fresh array
      end
      allocated[grantedArray] <= 1'b1;
    end else if (freeRequest) begin
      freeTop          <= freeTop + 1'b1;
      allocated[array] <= 1'b0;
    end
  end

  // Stack contents, only meaningful below freeTop
  always_ff @(posedge clock) begin
    if (freeRequest && !clearRequest && !allocRequest) begin
      freeStack[arrayPkg::arrayId'(freeTop)] <= array;
    end
  end

endmodule

// File: source/elementStore.sv
/*
  Element store: element memory and per-array size table,
  registered reads and single-cycle writes
*/
module elementStore (
  input logic     clock,
  input logic     resetN,
  storeBus.store  bus
);

  arrayPkg::dataWord     elements [arrayPkg::arrayCount][arrayPkg::arrayLength];
  arrayPkg::elementCount sizes    [arrayPkg::arrayCount];   // Size per array

  // ------------------------------------------------
  // Element memory
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (bus.writeEnable) begin
      elements[bus.array][bus.index] <= bus.writeData;
    end
    bus.readData <= elements[bus.array][bus.index];          // Old value on a write
  end

  // ------------------------------------------------
  // Size table
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrayPkg::arrayCount; i++) begin
        sizes[i] <= '0;
      end
      bus.currentSize <= '0;
    end else begin
      if (bus.sizeEnable) begin
        sizes[bus.array] <= bus.newSize;
      end
      bus.currentSize <= sizes[bus.array];                   // Size before this edge
    end
  end

endmodule

// File: source/elementAlu.sv
/*
  Read-modify-write unit for a single element
*/
module elementAlu (
  input  arrayPkg::arrayAction action,
  input  arrayPkg::dataWord    current,           // Element as stored
  input  arrayPkg::dataWord    operand,
  output arrayPkg::dataWord    newValue,          // Value to write back
  output arrayPkg::dataWord    returnValue        // Value to report
);

  always_comb begin
    case (action)
      arrayPkg::add,
      arrayPkg::addAfter: newValue = current + operand;    // Wraps in dataBits
      arrayPkg::subtract,
      arrayPkg::subAfter: newValue = current - operand;
      arrayPkg::bitOr:    newValue = current | operand;
      arrayPkg::bitXor:   newValue = current ^ operand;
      arrayPkg::bitAnd:   newValue = current & operand;
      default:            newValue = operand;              // Plain store for write and push
    endcase
  end

  // After forms hand back the element before the update
  assign returnValue = (action == arrayPkg::addAfter || action == arrayPkg::subAfter)
                       ? current : newValue;

endmodule

// File: source/arraySequencer.sv
/*
  Command FSM: latches a request, reads the store, checks and
  executes the command, then reports result and error with done
*/
module arraySequencer (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 start,
  input  arrayPkg::arrayAction action,
  input  arrayPkg::arrayId     array,
  input  arrayPkg::elementIndex index,
  input  arrayPkg::dataWord    operand,
  output logic                 busy,
  output logic                 done,
  output arrayPkg::dataWord    result,
  output arrayPkg::arrayError  error,
  storeBus.sequencer           bus,
  output logic                 allocRequest,
  output logic                 freeRequest,
  output logic                 clearRequest,
  output arrayPkg::arrayId     allocArray,       // Array for the allocator checks
  input  arrayPkg::arrayId     grantedArray,
  input  logic                 canAllocate,
  input  logic                 isAllocated,
  input  logic                 isBelowCount,
  output arrayPkg::arrayAction aluAction,
  output arrayPkg::dataWord    aluCurrent,
  output arrayPkg::dataWord    aluOperand,
  input  arrayPkg::dataWord    newValue,
  input  arrayPkg::dataWord    returnValue
);

  arrayPkg::sequencerState state;
  arrayPkg::arrayAction    reqAction;            // Latched request
  arrayPkg::arrayId        reqArray;
  arrayPkg::elementIndex   reqIndex;
  arrayPkg::dataWord       reqOperand;
  arrayPkg::arrayError     checkError;
  arrayPkg::dataWord       selectedResult;
  arrayPkg::arrayError     stagedError;          // Held from execute to finish
  arrayPkg::dataWord       stagedResult;
  logic                    isAlu;
  logic                    inExecute;
  logic                    passed;

  assign busy       = state != arrayPkg::idle;
  assign inExecute  = state == arrayPkg::execute;
  assign passed     = checkError == arrayPkg::none;
  assign allocArray = reqArray;
  assign aluAction  = reqAction;
  assign aluCurrent = bus.readData;
  assign aluOperand = reqOperand;
  assign isAlu      = reqAction inside {arrayPkg::add, arrayPkg::addAfter, arrayPkg::subtract,
                                        arrayPkg::subAfter, arrayPkg::bitOr, arrayPkg::bitXor,
                                        arrayPkg::bitAnd};

  // ------------------------------------------------
  // Request checks, valid in execute
  // ------------------------------------------------
  always_comb begin
    checkError = arrayPkg::none;
    case (reqAction)
      arrayPkg::heapReset: checkError = arrayPkg::none;
      arrayPkg::alloc: if (!canAllocate) checkError = arrayPkg::outOfMemory;
      default: begin
        if (!isBelowCount) checkError = arrayPkg::notAllocated;
        else if (!isAllocated) checkError = arrayPkg::freed;
        else if ((reqAction == arrayPkg::read || isAlu)
                 && arrayPkg::elementCount'(reqIndex) >= bus.currentSize)
          checkError = arrayPkg::outOfBounds;
        else if (reqAction == arrayPkg::push
                 && bus.currentSize == arrayPkg::elementCount'(arrayPkg::arrayLength))
          checkError = arrayPkg::arrayFull;
        else if (reqAction == arrayPkg::pop && bus.currentSize == '0)
          checkError = arrayPkg::arrayEmpty;
      end
    endcase
  end

  // ------------------------------------------------
  // Store addressing, writes and allocator pulses
  // ------------------------------------------------
  always_comb begin
    bus.array     = reqArray;
    bus.index     = reqIndex;
    bus.writeData = newValue;                    // Operand for write and push
    bus.writeEnable = 1'b0;
    bus.newSize   = '0;
    bus.sizeEnable = 1'b0;
    allocRequest  = 1'b0;
    freeRequest   = 1'b0;
    clearRequest  = 1'b0;
    if (state == arrayPkg::idle) begin
      bus.array = array;                         // Size ready by lookup
      bus.index = index;
    end else if (state == arrayPkg::lookup && reqAction == arrayPkg::pop) begin
      bus.index = arrayPkg::elementIndex'(bus.currentSize - 1'b1);   // Top element
    end else if (inExecute && passed) begin
      case (reqAction)
        arrayPkg::write: begin
          bus.writeEnable = 1'b1;
          bus.newSize     = arrayPkg::elementCount'(reqIndex) + 1'b1;
          bus.sizeEnable  = arrayPkg::elementCount'(reqIndex) >= bus.currentSize;  // Extend
        end
        arrayPkg::push: begin
          bus.index       = arrayPkg::elementIndex'(bus.currentSize);
          bus.writeEnable = 1'b1;
          bus.newSize     = bus.currentSize + 1'b1;
          bus.sizeEnable  = 1'b1;
        end
        arrayPkg::pop: begin
          bus.newSize    = bus.currentSize - 1'b1;
          bus.sizeEnable = 1'b1;
        end
        arrayPkg::alloc: begin
          bus.array      = grantedArray;         // Granted array starts empty
          bus.sizeEnable = 1'b1;
          allocRequest   = 1'b1;
        end
        arrayPkg::free:      freeRequest  = 1'b1;
        arrayPkg::heapReset: clearRequest = 1'b1;
        default:             bus.writeEnable = isAlu;
      endcase
    end
  end

  // Result per command, zero on failure
  always_comb begin
    selectedResult = '0;
    if (passed) begin
      case (reqAction)
        arrayPkg::read,
        arrayPkg::pop:   selectedResult = bus.readData;
        arrayPkg::size:  selectedResult = arrayPkg::dataWord'(bus.currentSize);
        arrayPkg::alloc: selectedResult = arrayPkg::dataWord'(grantedArray);
        arrayPkg::write: selectedResult = returnValue;
        default:         selectedResult = isAlu ? returnValue : '0;
      endcase
    end
  end

  // ------------------------------------------------
  // Request latch and staged outcome
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (state == arrayPkg::idle && start) begin
      reqAction  <= action;
      reqArray   <= array;
      reqIndex   <= index;
      reqOperand <= operand;
    end
    if (inExecute) begin
      stagedResult <= selectedResult;            // Before the allocator moves on
      stagedError  <= checkError;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state  <= arrayPkg::idle;
      done   <= 1'b0;
      result <= '0;
      error  <= arrayPkg::none;
    end else begin
      done <= 1'b0;
      unique case (state)
        arrayPkg::idle:    if (start) state <= arrayPkg::lookup;
        arrayPkg::lookup:  state <= arrayPkg::execute;     // Store read in flight
        arrayPkg::execute: state <= arrayPkg::finish;
        arrayPkg::finish: begin
          state  <= arrayPkg::idle;
          done   <= 1'b1;
          result <= stagedResult;
          error  <= stagedError;
        end
      endcase
    end
  end

endmodule

// File: source/arrayMemory.sv
/*
  Array heap top level: plain command ports wired to the
  allocator, element store, ALU and command sequencer
*/
module arrayMemory (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  start,           // Command strobe
  input  arrayPkg::arrayAction  action,
  input  arrayPkg::arrayId      array,
  input  arrayPkg::elementIndex index,
  input  arrayPkg::dataWord     operand,
  output logic                  busy,
  output logic                  done,            // One cycle per command
  output arrayPkg::dataWord     result,
  output arrayPkg::arrayError   error
);

  storeBus bus ();

  logic                 allocRequest;
  logic                 freeRequest;
  logic                 clearRequest;
  arrayPkg::arrayId     allocArray;
  arrayPkg::arrayId     grantedArray;
  logic                 canAllocate;
  logic                 isAllocated;
  logic                 isBelowCount;
  arrayPkg::arrayAction aluAction;
  arrayPkg::dataWord    aluCurrent;
  arrayPkg::dataWord    aluOperand;
  arrayPkg::dataWord    newValue;
  arrayPkg::dataWord    returnValue;

  arrayAllocator allocator (
    .clock, .resetN, .allocRequest, .freeRequest, .clearRequest,
    .array(allocArray), .grantedArray, .canAllocate, .isAllocated, .isBelowCount
  );

  elementStore store (.clock, .resetN, .bus(bus.store));

  elementAlu alu (
    .action(aluAction), .current(aluCurrent), .operand(aluOperand), .newValue, .returnValue
  );

  arraySequencer sequencer (
    .clock, .resetN, .start, .action, .array, .index, .operand,
    .busy, .done, .result, .error, .bus(bus.sequencer),
    .allocRequest, .freeRequest, .clearRequest, .allocArray,
    .grantedArray, .canAllocate, .isAllocated, .isBelowCount,
    .aluAction, .aluCurrent, .aluOperand, .newValue, .returnValue
  );

endmodule

// File: tests/arrayModel.svh
/*
  Reference model of the array heap: allocation state, element
  memory and sizes, xorshift generator and the expected outcome
*/
`ifndef arrayModelSvh
`define arrayModelSvh

// ------------------------------------------------
// Model state
// ------------------------------------------------
arrayPkg::dataWord modelElements [arrayPkg::arrayCount][arrayPkg::arrayLength];
int                modelSizes [arrayPkg::arrayCount] = '{default: 0};
arrayPkg::arrayId  modelStack [arrayPkg::arrayCount];  // Freed arrays, last on top
bit                modelFlags [arrayPkg::arrayCount] = '{default: 1'b0};
int                modelCount = 0;                      // Fresh arrays handed out
int                modelTop = 0;                        // Entries on the free stack

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  return x;
endfunction

// Applies one command to the model, gives expected result and error
function automatic void referenceCommand(
  input  arrayPkg::arrayAction  act,
  input  arrayPkg::arrayId      arr,
  input  arrayPkg::elementIndex idx,
  input  arrayPkg::dataWord     opnd,
  output arrayPkg::dataWord     expData,
  output arrayPkg::arrayError   expErr
);
  int                a;
  int                i;
  int                granted;
  arrayPkg::dataWord previous;
  arrayPkg::dataWord updated;
  a = int'(arr);
  i = int'(idx);
  expData = '0;                                         // Zero unless a value is due
  expErr = arrayPkg::none;
  if (act == arrayPkg::heapReset) begin
    modelCount = 0;                                     // Sizes and data stay behind
    modelTop = 0;
    foreach (modelFlags[k]) modelFlags[k] = 1'b0;
  end else if (act == arrayPkg::alloc) begin
    if (modelTop == 0 && modelCount == arrayPkg::arrayCount) begin
      expErr = arrayPkg::outOfMemory;
    end else begin
      if (modelTop > 0) begin
        modelTop--;                                     // Last freed goes out first
        granted = modelStack[modelTop];
      end else begin
        granted = modelCount;
        modelCount++;
      end
      modelFlags[granted] = 1'b1;
      modelSizes[granted] = 0;                          // New array starts empty
      expData = arrayPkg::dataWord'(granted);
    end
  end else if (a >= modelCount) begin
    expErr = arrayPkg::notAllocated;
  end else if (!modelFlags[a]) begin
    expErr = arrayPkg::freed;
  end else begin
    case (act)
      arrayPkg::write: begin
        modelElements[a][i] = opnd;
        if (i >= modelSizes[a]) modelSizes[a] = i + 1;  // Write past the end grows it
        expData = opnd;
      end
      arrayPkg::read: begin
        if (i >= modelSizes[a]) expErr = arrayPkg::outOfBounds;
        else expData = modelElements[a][i];
      end
      arrayPkg::size: expData = arrayPkg::dataWord'(modelSizes[a]);
      arrayPkg::push: begin
        if (modelSizes[a] == arrayPkg::arrayLength) begin
          expErr = arrayPkg::arrayFull;
        end else begin
          modelElements[a][modelSizes[a]] = opnd;
          modelSizes[a]++;
        end
      end
      arrayPkg::pop: begin
        if (modelSizes[a] == 0) begin
          expErr = arrayPkg::arrayEmpty;
        end else begin
          modelSizes[a]--;
          expData = modelElements[a][modelSizes[a]];
        end
      end
      arrayPkg::free: begin
        modelStack[modelTop] = arr;
        modelTop++;
        modelFlags[a] = 1'b0;
      end
      default: begin                                    // Read-modify-write forms
        if (i >= modelSizes[a]) begin
          expErr = arrayPkg::outOfBounds;
        end else begin
          previous = modelElements[a][i];
          case (act)
            arrayPkg::add, arrayPkg::addAfter:      updated = previous + opnd;
            arrayPkg::subtract, arrayPkg::subAfter: updated = previous - opnd;
            arrayPkg::bitOr:                        updated = previous | opnd;
            arrayPkg::bitXor:                       updated = previous ^ opnd;
            default:                                updated = previous & opnd;
          endcase
          modelElements[a][i] = updated;
          expData = (act == arrayPkg::addAfter || act == arrayPkg::subAfter)
                    ? previous : updated;
        end
      end
    endcase
  end
endfunction

`endif

// File: tests/arrayMemoryTb.sv
/*
  Array heap testbench with clock and reset, directed and
  random commands, expected-value queue and comparing process,
  compare tasks and watchdog
*/
module arrayMemoryTb;

  localparam int directedCount = 68;                    // Timing, heap, bounds, stack, ALU
  localparam int fillCount     = 1 + arrayPkg::arrayCount
                                 + arrayPkg::arrayCount * arrayPkg::arrayLength;
  localparam int randomCount   = 300;
  localparam int commandCount  = directedCount + fillCount + randomCount;

  logic                  clock;
  logic                  resetN;
  logic                  start;
  arrayPkg::arrayAction  action;
  arrayPkg::arrayId      array;
  arrayPkg::elementIndex index;
  arrayPkg::dataWord     operand;
  logic                  busy;
  logic                  done;
  arrayPkg::dataWord     result;
  arrayPkg::arrayError   error;

  string                 expectedNames [$];             // One entry per command in flight
  arrayPkg::dataWord     expectedData [$];
  arrayPkg::arrayError   expectedErrors [$];
  logic [31:0]           randomState = 32'd82676;

  `include "arrayModel.svh"

  arrayMemory dut (
    .clock, .resetN, .start, .action, .array, .index, .operand,
    .busy, .done, .result, .error
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------
  task automatic stopWithFailure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkData(input string name, input arrayPkg::dataWord expected,
                           input arrayPkg::dataWord actual);
    if (actual !== expected)
      stopWithFailure($sformatf("Mismatch in %s: expected result %h, actual %h",
                                name, expected, actual));
  endtask

  task automatic checkError(input string name, input arrayPkg::arrayError expected,
                            input arrayPkg::arrayError actual);
    if (actual !== expected)
      stopWithFailure($sformatf("Mismatch in %s: expected error %s (%0d), actual %s (%0d)",
                                name, expected.name(), expected, actual.name(), actual));
  endtask

  // Outputs are stable at the falling edge after done
  always @(negedge clock) begin : compareOutputs
    string name;
    if (done) begin
      if (expectedNames.size() == 0) begin
        stopWithFailure("done pulsed while no command was outstanding");
      end else begin
        name = expectedNames.pop_front();
        checkData(name, expectedData.pop_front(), result);
        checkError(name, expectedErrors.pop_front(), error);
      end
    end
  end

  initial begin : watchdog
    #(commandCount * 5 * 8 + 200);
    stopWithFailure("Timeout: the commands did not all finish in time");
  end

  // ------------------------------------------------
  // Command driving
  // ------------------------------------------------
  task automatic expectCommand(input string name, input arrayPkg::arrayAction act,
                               input arrayPkg::arrayId arr, input arrayPkg::elementIndex idx,
                               input arrayPkg::dataWord opnd);
    arrayPkg::dataWord   expData;
    arrayPkg::arrayError expErr;
    referenceCommand(act, arr, idx, opnd, expData, expErr);
    expectedNames.push_back(name);
    expectedData.push_back(expData);
    expectedErrors.push_back(expErr);
  endtask

  task automatic runCommand(input string name, input arrayPkg::arrayAction act,
                            input arrayPkg::arrayId arr, input arrayPkg::elementIndex idx,
                            input arrayPkg::dataWord opnd);
    expectCommand(name, act, arr, idx, opnd);
    @(posedge clock);
    start   <= 1'b1;
    action  <= act;
    array   <= arr;
    index   <= idx;
    operand <= opnd;
    @(posedge clock);                                   // Sampled here
    start <= 1'b0;
    do @(negedge clock); while (!done);
  endtask

  task automatic checkResetState();
    if (busy !== 1'b0 || done !== 1'b0)
      stopWithFailure("busy or done is not low after reset");
    checkData("reset state", '0, result);
    checkError("reset state", arrayPkg::none, error);
  endtask

  // An accepted alloc followed by a heap reset raised while busy
  task automatic checkStartTiming();
    expectCommand("start timing", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    @(posedge clock);
    start   <= 1'b1;
    action  <= arrayPkg::alloc;
    array   <= 2'd0;
    index   <= 3'd0;
    operand <= 16'h0;
    @(posedge clock);                                   // Sampling edge
    start <= 1'b0;
    @(negedge clock);
    if (busy !== 1'b1 || done !== 1'b0)
      stopWithFailure("busy did not rise on the accepted start");
    @(posedge clock);
    start  <= 1'b1;                                     // Lands while busy
    action <= arrayPkg::heapReset;
    @(negedge clock);
    if (done !== 1'b0) stopWithFailure("done came one edge after the start");
    @(posedge clock);
    start <= 1'b0;
    @(negedge clock);
    if (done !== 1'b0) stopWithFailure("done came two edges after the start");
    @(posedge clock);                                   // Third edge
    @(negedge clock);
    if (done !== 1'b1 || busy !== 1'b0)
      stopWithFailure("done and busy did not change three edges after the start");
    @(posedge clock);
    @(negedge clock);
    if (done !== 1'b0 || busy !== 1'b0)
      stopWithFailure("a start raised while busy was not ignored");
  endtask

  // ------------------------------------------------
  // Directed groups
  // ------------------------------------------------
  task automatic runHeapTests();
    runCommand("heap reset", arrayPkg::heapReset, 2'd0, 3'd0, 16'h0);
    for (int k = 0; k < arrayPkg::arrayCount; k++)
      runCommand($sformatf("alloc %0d", k), arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    runCommand("alloc when exhausted", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    runCommand("free 2", arrayPkg::free, 2'd2, 3'd0, 16'h0);
    runCommand("free 1", arrayPkg::free, 2'd1, 3'd0, 16'h0);
    runCommand("realloc last freed", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    runCommand("realloc first freed", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    runCommand("free 3", arrayPkg::free, 2'd3, 3'd0, 16'h0);
    runCommand("free 3 twice", arrayPkg::free, 2'd3, 3'd0, 16'h0);
    runCommand("second heap reset", arrayPkg::heapReset, 2'd0, 3'd0, 16'h0);
    runCommand("alloc after reset", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    runCommand("size never allocated", arrayPkg::size, 2'd3, 3'd0, 16'h0);
    runCommand("write never allocated", arrayPkg::write, 2'd2, 3'd1, 16'h5555);
  endtask

  task automatic runBoundsTests();
    runCommand("alloc for bounds", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    runCommand("write extends size", arrayPkg::write, 2'd0, 3'd2, 16'h1234);
    runCommand("size after extend", arrayPkg::size, 2'd0, 3'd0, 16'h0);
    runCommand("read index 2", arrayPkg::read, 2'd0, 3'd2, 16'h0);
    runCommand("write index 0", arrayPkg::write, 2'd0, 3'd0, 16'hBEEF);
    runCommand("write index 1", arrayPkg::write, 2'd0, 3'd1, 16'h0F0F);
    runCommand("size unchanged", arrayPkg::size, 2'd0, 3'd0, 16'h0);
    runCommand("read index 0", arrayPkg::read, 2'd0, 3'd0, 16'h0);
    runCommand("read index 1", arrayPkg::read, 2'd0, 3'd1, 16'h0);
    runCommand("read at size", arrayPkg::read, 2'd0, 3'd3, 16'h0);
    runCommand("read past size", arrayPkg::read, 2'd0, 3'd7, 16'h0);
  endtask

  task automatic runStackTests();
    for (int k = 0; k < arrayPkg::arrayLength; k++)
      runCommand($sformatf("push %0d", k), arrayPkg::push, 2'd1, 3'd0,
                 16'h0100 + 16'(k) * 16'h0011);
    runCommand("push to full array", arrayPkg::push, 2'd1, 3'd0, 16'hDEAD);
    runCommand("size of full array", arrayPkg::size, 2'd1, 3'd0, 16'h0);
    for (int k = 0; k < arrayPkg::arrayLength; k++)
      runCommand($sformatf("pop %0d", k), arrayPkg::pop, 2'd1, 3'd0, 16'h0);
    runCommand("pop from empty array", arrayPkg::pop, 2'd1, 3'd0, 16'h0);
  endtask

  task automatic runAluTests();
    arrayPkg::arrayAction aluActions [7];
    arrayPkg::dataWord    base;
    arrayPkg::dataWord    value;
    aluActions = '{arrayPkg::add, arrayPkg::addAfter, arrayPkg::subtract,
                   arrayPkg::subAfter, arrayPkg::bitOr, arrayPkg::bitXor, arrayPkg::bitAnd};
    for (int k = 0; k < 7; k++) begin
      base  = 16'hF0F0 + 16'(k) * 16'h0123;
      value = 16'hF00F ^ (16'(k) * 16'h2222);             // Add forms wrap
      runCommand("element before ALU", arrayPkg::write, 2'd0, 3'd0, base);
      runCommand(aluActions[k].name(), aluActions[k], 2'd0, 3'd0, value);
      runCommand("read after ALU", arrayPkg::read, 2'd0, 3'd0, 16'h0);
    end
  endtask

  // ------------------------------------------------
  // Random phase
  // ------------------------------------------------
  function automatic arrayPkg::dataWord fillWord(input int a, input int i);
    return {4'(a), 4'(i), 8'((a * 8 + i) * 29)};
  endfunction

  // Every element gets a known value before random reads
  task automatic fillAllArrays();
    runCommand("fill heap reset", arrayPkg::heapReset, 2'd0, 3'd0, 16'h0);
    for (int a = 0; a < arrayPkg::arrayCount; a++)
      runCommand("fill alloc", arrayPkg::alloc, 2'd0, 3'd0, 16'h0);
    for (int a = 0; a < arrayPkg::arrayCount; a++)
      for (int i = 0; i < arrayPkg::arrayLength; i++)
        runCommand($sformatf("fill %0d.%0d", a, i), arrayPkg::write,
                   arrayPkg::arrayId'(a), arrayPkg::elementIndex'(i), fillWord(a, i));
  endtask

  task automatic runRandomCommands();
    arrayPkg::arrayAction pool [16];
    arrayPkg::arrayAction act;
    logic [31:0]          draw;
    pool = '{arrayPkg::write, arrayPkg::read, arrayPkg::size, arrayPkg::push,
             arrayPkg::pop, arrayPkg::alloc, arrayPkg::free, arrayPkg::add,
             arrayPkg::addAfter, arrayPkg::subtract, arrayPkg::subAfter, arrayPkg::bitOr,
             arrayPkg::bitXor, arrayPkg::bitAnd, arrayPkg::alloc, arrayPkg::write};
    for (int n = 0; n < randomCount; n++) begin
      randomState = xorshift(randomState);
      draw = randomState;
      act = (draw[9:4] == '0 || n == 150) ? arrayPkg::heapReset : pool[draw[3:0]];
      randomState = xorshift(randomState);                // Fresh draw for the operand
      runCommand($sformatf("random %0d %s", n, act.name()), act,
                 draw[11:10], draw[14:12], randomState[15:0]);
    end
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin : stimulus
    resetN  = 1'b0;
    start   = 1'b0;
    action  = arrayPkg::heapReset;
    array   = '0;
    index   = '0;
    operand = '0;
    repeat (4) @(posedge clock);
    resetN <= 1'b1;
    @(negedge clock);
    checkResetState();
    checkStartTiming();
    runHeapTests();
    runBoundsTests();
    runStackTests();
    runAluTests();
    fillAllArrays();
    runRandomCommands();
    @(negedge clock);                                   // Last compare has run
    $display("** PASS **");
    $finish;
  end

endmodule

// File: arrayMemory.f
+incdir+tests
source/arrayPkg.sv
source/storeBus.sv
source/arrayAllocator.sv
source/elementStore.sv
source/elementAlu.sv
source/arraySequencer.sv
source/arrayMemory.sv
tests/arrayMemoryTb.sv
